// File: hdl/mmap_pkg.sv
package mmap_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths and counts
    ////////////////////////////////////////////////////////////////////////////
    localparam int DATA_W     = 18;
    localparam int RAM_ADDR_W = 14;
    localparam int BUS_ADDR_W = 16;
    localparam int NUM_GUNS   = 2;
    localparam int NUM_SOUNDS = 8;
    localparam int RAND_W     = 10;
    localparam int HIT_WINDOW = 16;

    // derived widths
    localparam int GUN_W = $clog2(NUM_GUNS);
    localparam int WIN_W = $clog2(HIT_WINDOW + 1);

    typedef logic [BUS_ADDR_W-1:0] bus_addr_t;
    typedef logic [GUN_W-1:0]      gun_idx_t;
    typedef logic [WIN_W-1:0]      win_cnt_t;

    localparam logic [RAND_W-1:0] LFSR_SEED = 10'h001;

    ////////////////////////////////////////////////////////////////////////////
    // address map of port B
    ////////////////////////////////////////////////////////////////////////////
    localparam logic [7:0] IO_PAGE = 8'h20;

    // gun g sits at base + 2g
    localparam bus_addr_t TRIG_BASE      = 16'h2000;
    localparam bus_addr_t SENS_BASE      = 16'h2001;
    localparam bus_addr_t RAND8_ADDR     = 16'h2008;
    localparam bus_addr_t RAND9_ADDR     = 16'h2009;
    localparam bus_addr_t RAND10_ADDR    = 16'h2010;
    localparam bus_addr_t SOUND_ON_BASE  = 16'h2020;
    localparam bus_addr_t SOUND_OFF_BASE = 16'h2030;

    // bit that selects the video window
    localparam int VID_MSB = 15;

    // read sources for the port-B data mux
    typedef enum logic [2:0] {
        SEL_RAM,
        SEL_SHOT,
        SEL_HIT,
        SEL_RAND8,
        SEL_RAND9,
        SEL_RAND10,
        SEL_ZERO
    } io_sel_e;

endpackage

// File: hdl/dp_ram.sv
`timescale 1ns/1ps

module dp_ram (
    input  logic                            a_clk,
    // cpu side
    input  logic                            a_wr,
    input  logic [mmap_pkg::RAM_ADDR_W-1:0] a_addr,
    input  logic [mmap_pkg::DATA_W-1:0]     a_din,
    output logic [mmap_pkg::DATA_W-1:0]     a_dout,
    // bus side
    input  logic                            b_wr,
    input  logic [mmap_pkg::RAM_ADDR_W-1:0] b_addr,
    input  logic [mmap_pkg::DATA_W-1:0]     b_din,
    output logic [mmap_pkg::DATA_W-1:0]     b_dout
);

    logic [mmap_pkg::DATA_W-1:0] mem [2**mmap_pkg::RAM_ADDR_W];

    // port a, write-first
    always @(posedge a_clk) begin
        if (a_wr) begin
            mem[a_addr] <= a_din;
            a_dout      <= a_din;
        end else begin
            a_dout <= mem[a_addr];
        end
    end

    // port b, write-first
    always @(posedge a_clk) begin
        if (b_wr) begin
            mem[b_addr] <= b_din;
            b_dout      <= b_din;
        end else begin
            b_dout <= mem[b_addr];
        end
    end

    // cpu and bus writing one word together leaves it undefined
    a_same_addr_wr: assert property (@(posedge a_clk) !(a_wr && b_wr && (a_addr == b_addr)))
        else $warning("dp_ram: both ports write address %h in one cycle", a_addr);

endmodule

// File: hdl/lfsr_rand.sv
`timescale 1ns/1ps

module lfsr_rand (
    input  logic                        a_clk,
    input  logic                        rst_n,
    output logic [mmap_pkg::RAND_W-1:0] rand_out
);

    logic feedback;

    // taps 10 and 7, maximal length
    assign feedback = rand_out[9] ^ rand_out[6];

    always_ff @(posedge a_clk) begin
        if (!rst_n) begin
            rand_out <= mmap_pkg::LFSR_SEED;
        end else begin
            rand_out <= {rand_out[mmap_pkg::RAND_W-2:0], feedback};
        end
    end

    // zero state would lock the shifter up for good
    a_never_zero: assert property (
        @(posedge a_clk) disable iff (!rst_n) rand_out != '0
    ) else $error("lfsr_rand: register reached all zeros");

endmodule

// File: hdl/gun_channel.sv
`timescale 1ns/1ps

module gun_channel (
    input  logic a_clk,
    input  logic rst_n,
    input  logic trigger,
    input  logic sens,
    input  logic shot_clr,
    input  logic hit_clr,
    output logic shot,
    output logic hit
);

    logic                trig_s1;
    logic                trig_s2;
    logic                trig_d;
    logic                sens_s1;
    logic                sens_s2;
    logic                trig_rise;
    mmap_pkg::win_cnt_t  win_cnt;

    ////////////////////////////////////////////////////////////////////////////
    // input synchronisers
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge a_clk) begin
        if (!rst_n) begin
            trig_s1 <= 1'b0;
            trig_s2 <= 1'b0;
            trig_d  <= 1'b0;
            sens_s1 <= 1'b0;
            sens_s2 <= 1'b0;
        end else begin
            trig_s1 <= trigger;
            trig_s2 <= trig_s1;
            trig_d  <= trig_s2;
            sens_s1 <= sens;
            sens_s2 <= sens_s1;
        end
    end

    assign trig_rise = trig_s2 & ~trig_d;

    ////////////////////////////////////////////////////////////////////////////
    // flags and hit window
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge a_clk) begin
        if (!rst_n) begin
            shot    <= 1'b0;
            hit     <= 1'b0;
            win_cnt <= '0;
        end else begin
            // clear beats set
            if (shot_clr) begin
                shot <= 1'b0;
            end else if (trig_rise) begin
                shot <= 1'b1;
            end

            if (hit_clr) begin
                hit <= 1'b0;
            end else if ((win_cnt != '0) && sens_s2) begin
                hit <= 1'b1;
            end

            // window opens with the shot
            if (trig_rise) begin
                win_cnt <= mmap_pkg::win_cnt_t'(mmap_pkg::HIT_WINDOW);
            end else if (win_cnt != '0) begin
                win_cnt <= win_cnt - 1'b1;
            end
        end
    end

endmodule

// File: hdl/io_decode.sv
`timescale 1ns/1ps

module io_decode (
    input  logic                            a_clk,
    input  logic                            rst_n,
    input  logic                            b_rd,
    input  logic                            b_wr,
    input  logic [mmap_pkg::BUS_ADDR_W-1:0] b_addr,
    input  logic [mmap_pkg::DATA_W-1:0]     b_din,
    output logic                            ram_wr,
    output logic                            vid_wr,
    output logic [mmap_pkg::BUS_ADDR_W-1:0] vid_addr,
    output logic [mmap_pkg::DATA_W-1:0]     vid_din,
    output logic [mmap_pkg::NUM_GUNS-1:0]   shot_clr,
    output logic [mmap_pkg::NUM_GUNS-1:0]   hit_clr,
    output logic [mmap_pkg::NUM_SOUNDS-1:0] sound,
    output mmap_pkg::io_sel_e               rd_sel,
    output mmap_pkg::gun_idx_t              rd_gun
);

    logic                          in_io;
    logic                          in_vid;
    logic [mmap_pkg::NUM_GUNS-1:0] trig_match;
    logic [mmap_pkg::NUM_GUNS-1:0] sens_match;

    // region classification
    assign in_io  = (b_addr[mmap_pkg::BUS_ADDR_W-1 -: 8] == mmap_pkg::IO_PAGE);
    assign in_vid = b_addr[mmap_pkg::VID_MSB];
    assign ram_wr = b_wr & ~in_io & ~in_vid;

    for (genvar g = 0; g < mmap_pkg::NUM_GUNS; g++) begin : g_gun_match
        assign trig_match[g] = (b_addr == mmap_pkg::TRIG_BASE + mmap_pkg::bus_addr_t'(2 * g));
        assign sens_match[g] = (b_addr == mmap_pkg::SENS_BASE + mmap_pkg::bus_addr_t'(2 * g));
    end

    // read-to-clear strobes
    assign shot_clr = trig_match & {mmap_pkg::NUM_GUNS{b_rd}};
    assign hit_clr  = sens_match & {mmap_pkg::NUM_GUNS{b_rd}};

    ////////////////////////////////////////////////////////////////////////////
    // read source selection
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        rd_sel = mmap_pkg::SEL_RAM;
        rd_gun = '0;
        if (in_vid) begin
            rd_sel = mmap_pkg::SEL_ZERO;
        end else if (in_io) begin
            rd_sel = mmap_pkg::SEL_ZERO;
            if (b_addr == mmap_pkg::RAND8_ADDR) begin
                rd_sel = mmap_pkg::SEL_RAND8;
            end else if (b_addr == mmap_pkg::RAND9_ADDR) begin
                rd_sel = mmap_pkg::SEL_RAND9;
            end else if (b_addr == mmap_pkg::RAND10_ADDR) begin
                rd_sel = mmap_pkg::SEL_RAND10;
            end
            for (int g = 0; g < mmap_pkg::NUM_GUNS; g++) begin
                if (trig_match[g]) begin
                    rd_sel = mmap_pkg::SEL_SHOT;
                    rd_gun = mmap_pkg::gun_idx_t'(g);
                end else if (sens_match[g]) begin
                    rd_sel = mmap_pkg::SEL_HIT;
                    rd_gun = mmap_pkg::gun_idx_t'(g);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // sound lines and video write
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge a_clk) begin
        if (!rst_n) begin
            sound  <= '0;
            vid_wr <= 1'b0;
        end else begin
            vid_wr <= b_wr & in_vid;
            for (int n = 0; n < mmap_pkg::NUM_SOUNDS; n++) begin
                if (b_wr && b_addr == mmap_pkg::SOUND_ON_BASE + mmap_pkg::bus_addr_t'(n)) begin
                    sound[n] <= 1'b1;
                end else if (b_wr && b_addr == mmap_pkg::SOUND_OFF_BASE
                                               + mmap_pkg::bus_addr_t'(n)) begin
                    sound[n] <= 1'b0;
                end
            end
        end
    end

    // video payload, qualified by vid_wr
    always_ff @(posedge a_clk) begin
        if (b_wr && in_vid) begin
            vid_addr <= b_addr;
            vid_din  <= b_din;
        end
    end

    a_rd_wr_excl: assert property (
        @(posedge a_clk) disable iff (!rst_n) !(b_rd && b_wr)
    ) else $error("io_decode: b_rd and b_wr high together");

endmodule

// File: hdl/io_readback.sv
`timescale 1ns/1ps

module io_readback (
    input  logic                          a_clk,
    input  logic                          rst_n,
    input  logic                          b_rd,
    input  mmap_pkg::io_sel_e             rd_sel,
    input  mmap_pkg::gun_idx_t            rd_gun,
    input  logic [mmap_pkg::NUM_GUNS-1:0] shot,
    input  logic [mmap_pkg::NUM_GUNS-1:0] hit,
    input  logic [mmap_pkg::RAND_W-1:0]   rand_out,
    input  logic [mmap_pkg::DATA_W-1:0]   ram_dout,
    output logic [mmap_pkg::DATA_W-1:0]   b_dout
);

    mmap_pkg::io_sel_e           sel_q;
    logic                        rd_q;
    logic [mmap_pkg::DATA_W-1:0] io_val;
    logic [mmap_pkg::DATA_W-1:0] io_q;

    // value of the selected I/O source at the read edge
    always_comb begin
        io_val = '0;
        case (rd_sel)
            mmap_pkg::SEL_SHOT:   io_val[0] = shot[rd_gun];
            mmap_pkg::SEL_HIT:    io_val[0] = hit[rd_gun];
            mmap_pkg::SEL_RAND8:  io_val[7:0] = rand_out[7:0];
            mmap_pkg::SEL_RAND9:  io_val[8:0] = rand_out[8:0];
            mmap_pkg::SEL_RAND10: io_val[mmap_pkg::RAND_W-1:0] = rand_out;
            default:              io_val = '0;
        endcase
    end

    always_ff @(posedge a_clk) begin
        if (!rst_n) begin
            sel_q <= mmap_pkg::SEL_ZERO;
            rd_q  <= 1'b0;
            io_q  <= '0;
        end else begin
            rd_q <= b_rd;
            if (b_rd) begin
                sel_q <= rd_sel;
                io_q  <= io_val;
            end else if (rd_q && sel_q == mmap_pkg::SEL_RAM) begin
                // keep the RAM word once port B moves on
                io_q <= ram_dout;
            end
        end
    end

    assign b_dout = (rd_q && sel_q == mmap_pkg::SEL_RAM) ? ram_dout : io_q;

endmodule

// File: hdl/memory_map_top.sv
`timescale 1ns/1ps

module memory_map_top (
    input  logic                            a_clk,
    input  logic                            rst_n,
    // port a, cpu
    input  logic                            a_wr,
    input  logic [mmap_pkg::RAM_ADDR_W-1:0] a_addr,
    input  logic [mmap_pkg::DATA_W-1:0]     a_din,
    output logic [mmap_pkg::DATA_W-1:0]     a_dout,
    // port b, memory-mapped bus
    input  logic                            b_rd,
    input  logic                            b_wr,
    input  logic [mmap_pkg::BUS_ADDR_W-1:0] b_addr,
    input  logic [mmap_pkg::DATA_W-1:0]     b_din,
    output logic [mmap_pkg::DATA_W-1:0]     b_dout,
    // light guns
    input  logic [mmap_pkg::NUM_GUNS-1:0]   p_trigger,
    input  logic [mmap_pkg::NUM_GUNS-1:0]   p_sens,
    output logic [mmap_pkg::NUM_GUNS-1:0]   shot,
    output logic [mmap_pkg::NUM_GUNS-1:0]   hit,
    // misc I/O
    output logic [mmap_pkg::NUM_SOUNDS-1:0] sound,
    output logic [mmap_pkg::RAND_W-1:0]     rand_out,
    output logic                            vid_wr,
    output logic [mmap_pkg::BUS_ADDR_W-1:0] vid_addr,
    output logic [mmap_pkg::DATA_W-1:0]     vid_din
);

    logic                          ram_wr;
    logic [mmap_pkg::DATA_W-1:0]   ram_dout;
    logic [mmap_pkg::NUM_GUNS-1:0] shot_clr;
    logic [mmap_pkg::NUM_GUNS-1:0] hit_clr;
    mmap_pkg::io_sel_e             rd_sel;
    mmap_pkg::gun_idx_t            rd_gun;

    dp_ram dp_ram_inst (
        .a_clk  (a_clk),
        .a_wr   (a_wr),
        .a_addr (a_addr),
        .a_din  (a_din),
        .a_dout (a_dout),
        .b_wr   (ram_wr),
        .b_addr (b_addr[mmap_pkg::RAM_ADDR_W-1:0]),
        .b_din  (b_din),
        .b_dout (ram_dout)
    );

    lfsr_rand lfsr_rand_inst (
        .a_clk    (a_clk),
        .rst_n    (rst_n),
        .rand_out (rand_out)
    );

    io_decode io_decode_inst (
        .a_clk    (a_clk),
        .rst_n    (rst_n),
        .b_rd     (b_rd),
        .b_wr     (b_wr),
        .b_addr   (b_addr),
        .b_din    (b_din),
        .ram_wr   (ram_wr),
        .vid_wr   (vid_wr),
        .vid_addr (vid_addr),
        .vid_din  (vid_din),
        .shot_clr (shot_clr),
        .hit_clr  (hit_clr),
        .sound    (sound),
        .rd_sel   (rd_sel),
        .rd_gun   (rd_gun)
    );

    // one channel per gun
    for (genvar g = 0; g < mmap_pkg::NUM_GUNS; g++) begin : g_gun
        gun_channel gun_channel_inst (
            .a_clk    (a_clk),
            .rst_n    (rst_n),
            .trigger  (p_trigger[g]),
            .sens     (p_sens[g]),
            .shot_clr (shot_clr[g]),
            .hit_clr  (hit_clr[g]),
            .shot     (shot[g]),
            .hit      (hit[g])
        );
    end

    io_readback io_readback_inst (
        .a_clk    (a_clk),
        .rst_n    (rst_n),
        .b_rd     (b_rd),
        .rd_sel   (rd_sel),
        .rd_gun   (rd_gun),
        .shot     (shot),
        .hit      (hit),
        .rand_out (rand_out),
        .ram_dout (ram_dout),
        .b_dout   (b_dout)
    );

endmodule

// File: dv/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic a_clk,
    output logic rst_n
);

    // 4 ns period
    initial begin
        a_clk = 1'b0;
        forever #2 a_clk = ~a_clk;
    end

    // reset for 10 rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge a_clk);
        @(negedge a_clk);
        rst_n = 1'b1;
    end

endmodule

// File: dv/memory_map_tb.sv
`timescale 1ns/1ps

module memory_map_tb;

    localparam int   FLAG_TIMEOUT  = 20;
    localparam int   RESET_TIMEOUT = 50;
    localparam logic BY_MODEL      = 1'b1;
    localparam logic BY_TABLE      = 1'b0;

    typedef enum logic [2:0] {OP_AWR, OP_ARD, OP_BWR, OP_BRD, OP_TRIG, OP_SENS, OP_IDLE} op_e;

    // addr carries the gun index for gun pulses and the length of an idle row
    typedef struct packed {
        logic [2:0]                      op;
        logic [mmap_pkg::BUS_ADDR_W-1:0] addr;
        logic [mmap_pkg::DATA_W-1:0]     data;
        logic [mmap_pkg::DATA_W-1:0]     exp;
        logic                            by_model;
    } row_t;

    logic                            a_clk;
    logic                            rst_n;
    logic                            a_wr;
    logic [mmap_pkg::RAM_ADDR_W-1:0] a_addr;
    logic [mmap_pkg::DATA_W-1:0]     a_din;
    logic [mmap_pkg::DATA_W-1:0]     a_dout;
    logic                            b_rd;
    logic                            b_wr;
    logic [mmap_pkg::BUS_ADDR_W-1:0] b_addr;
    logic [mmap_pkg::DATA_W-1:0]     b_din;
    logic [mmap_pkg::DATA_W-1:0]     b_dout;
    logic [mmap_pkg::NUM_GUNS-1:0]   p_trigger;
    logic [mmap_pkg::NUM_GUNS-1:0]   p_sens;
    logic [mmap_pkg::NUM_GUNS-1:0]   shot;
    logic [mmap_pkg::NUM_GUNS-1:0]   hit;
    logic [mmap_pkg::NUM_SOUNDS-1:0] sound;
    logic [mmap_pkg::RAND_W-1:0]     rand_out;
    logic                            vid_wr;
    logic [mmap_pkg::BUS_ADDR_W-1:0] vid_addr;
    logic [mmap_pkg::DATA_W-1:0]     vid_din;

    // reference models
    logic [mmap_pkg::DATA_W-1:0]     ram_m [2**mmap_pkg::RAM_ADDR_W];
    logic [mmap_pkg::NUM_SOUNDS-1:0] sound_m;
    logic [mmap_pkg::RAND_W-1:0]     lfsr_m;
    logic                            lfsr_chk_on;
    row_t                            rows_q [$];

    tb_clk_gen tb_clk_gen_inst (
        .a_clk (a_clk),
        .rst_n (rst_n)
    );

    memory_map_top memory_map_top_inst (
        .a_clk     (a_clk),
        .rst_n     (rst_n),
        .a_wr      (a_wr),
        .a_addr    (a_addr),
        .a_din     (a_din),
        .a_dout    (a_dout),
        .b_rd      (b_rd),
        .b_wr      (b_wr),
        .b_addr    (b_addr),
        .b_din     (b_din),
        .b_dout    (b_dout),
        .p_trigger (p_trigger),
        .p_sens    (p_sens),
        .shot      (shot),
        .hit       (hit),
        .sound     (sound),
        .rand_out  (rand_out),
        .vid_wr    (vid_wr),
        .vid_addr  (vid_addr),
        .vid_din   (vid_din)
    );

    ////////////////////////////////////////////////////////////////////////////
    // models and checks
    ////////////////////////////////////////////////////////////////////////////

    // taps 10 and 7, new bit enters at the bottom
    function automatic logic [mmap_pkg::RAND_W-1:0] lfsr_next(input logic [9:0] v);
        return {v[8:0], v[9] ^ v[6]};
    endfunction

    always @(posedge a_clk) begin
        lfsr_m <= !rst_n ? mmap_pkg::LFSR_SEED : lfsr_next(lfsr_m);
    end

    function automatic logic [mmap_pkg::DATA_W-1:0] model_read(input logic [15:0] addr);
        logic [mmap_pkg::DATA_W-1:0] v;
        v = '0;
        if (addr[mmap_pkg::VID_MSB]) begin
            v = '0;
        end else if (addr[15:8] == mmap_pkg::IO_PAGE) begin
            if (addr == mmap_pkg::RAND8_ADDR) v[7:0] = lfsr_m[7:0];
            if (addr == mmap_pkg::RAND9_ADDR) v[8:0] = lfsr_m[8:0];
            if (addr == mmap_pkg::RAND10_ADDR) v[mmap_pkg::RAND_W-1:0] = lfsr_m;
        end else begin
            v = ram_m[addr[mmap_pkg::RAM_ADDR_W-1:0]];
        end
        return v;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            $display("TB FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // random source tracked on every cycle
    always @(negedge a_clk) begin
        if (lfsr_chk_on) check_eq("rand_out", rand_out, lfsr_m);
    end

    task automatic wait_flag_set(input logic is_hit, input int g);
        int   cnt;
        logic seen;
        cnt  = 0;
        seen = 1'b0;
        while (!seen && cnt < FLAG_TIMEOUT) begin
            @(negedge a_clk);
            cnt++;
            seen = ((is_hit ? hit[g] : shot[g]) === 1'b1);
        end
        if (!seen) begin
            $display("timeout: %s flag of gun %0d never set", is_hit ? "hit" : "shot", g);
            $display("TB FAILED");
            $fatal(1, "flag wait timed out");
        end
    endtask

    task automatic wait_reset_release();
        int cnt;
        cnt = 0;
        while (rst_n !== 1'b1 && cnt < RESET_TIMEOUT) begin
            @(posedge a_clk);
            cnt++;
        end
        if (rst_n !== 1'b1) begin
            $display("timeout: reset was never released");
            $display("TB FAILED");
            $fatal(1, "reset wait timed out");
        end
    endtask

    task automatic update_write_models(input logic [15:0] addr, input logic [17:0] data);
        // RAM sees only writes below the video window and outside the I/O page
        if (!addr[mmap_pkg::VID_MSB] && addr[15:8] != mmap_pkg::IO_PAGE) begin
            ram_m[addr[mmap_pkg::RAM_ADDR_W-1:0]] = data;
        end
        for (int n = 0; n < mmap_pkg::NUM_SOUNDS; n++) begin
            if (addr == mmap_pkg::SOUND_ON_BASE + n) sound_m[n] = 1'b1;
            else if (addr == mmap_pkg::SOUND_OFF_BASE + n) sound_m[n] = 1'b0;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////////////////////////////////////////
    task automatic add_row(input op_e op, input int addr, input int exp, input logic by_model);
        row_t        r;
        logic [31:0] rnd;
        rnd        = $urandom();
        r.op       = op;
        r.addr     = addr[mmap_pkg::BUS_ADDR_W-1:0];
        r.data     = rnd[mmap_pkg::DATA_W-1:0];
        r.exp      = exp[mmap_pkg::DATA_W-1:0];
        r.by_model = by_model;
        rows_q.push_back(r);
    endtask

    task automatic build_table();
        // RAM both ways
        add_row(OP_AWR, 'h0010, 0, BY_MODEL);
        add_row(OP_BRD, 'h0010, 0, BY_MODEL);
        add_row(OP_AWR, 'h1fff, 0, BY_MODEL);
        add_row(OP_BRD, 'h1fff, 0, BY_MODEL);
        add_row(OP_BWR, 'h0020, 0, BY_MODEL);
        add_row(OP_ARD, 'h0020, 0, BY_MODEL);
        add_row(OP_BWR, 'h3abc, 0, BY_MODEL);
        add_row(OP_ARD, 'h3abc, 0, BY_MODEL);
        add_row(OP_BRD, 'h3abc, 0, BY_MODEL);
        // I/O page write must not reach RAM
        add_row(OP_AWR, 'h2005, 0, BY_MODEL);
        add_row(OP_BWR, 'h2005, 0, BY_MODEL);
        add_row(OP_ARD, 'h2005, 0, BY_MODEL);
        add_row(OP_BRD, 'h2005, 0, BY_MODEL);
        // sound lines
        add_row(OP_BWR, 'h2023, 0, BY_MODEL);
        add_row(OP_BWR, 'h2027, 0, BY_MODEL);
        add_row(OP_BWR, 'h2020, 0, BY_MODEL);
        add_row(OP_BWR, 'h2033, 0, BY_MODEL);
        add_row(OP_BWR, 'h2037, 0, BY_MODEL);
        // random reads, spread over many LFSR states so the upper bits show up
        for (int i = 0; i < 8; i++) begin
            add_row(OP_BRD, 'h2008, 0, BY_MODEL);
            add_row(OP_BRD, 'h2009, 0, BY_MODEL);
            add_row(OP_BRD, 'h2010, 0, BY_MODEL);
        end
        // video window
        add_row(OP_AWR, 'h0123, 0, BY_MODEL);
        add_row(OP_BWR, 'h8123, 0, BY_MODEL);
        add_row(OP_BRD, 'h8123, 0, BY_MODEL);
        add_row(OP_BRD, 'h0123, 0, BY_MODEL);
        // guns, flags clear on read
        for (int g = 0; g < mmap_pkg::NUM_GUNS; g++) begin
            add_row(OP_TRIG, g, 1, BY_TABLE);
            add_row(OP_SENS, g, 1, BY_TABLE);
            add_row(OP_BRD, 'h2000 + 2 * g, 1, BY_TABLE);
            add_row(OP_BRD, 'h2000 + 2 * g, 0, BY_TABLE);
            add_row(OP_BRD, 'h2001 + 2 * g, 1, BY_TABLE);
            add_row(OP_BRD, 'h2001 + 2 * g, 0, BY_TABLE);
        end
        // sensor with the window long closed
        add_row(OP_IDLE, 20, 0, BY_TABLE);
        add_row(OP_SENS, 0, 0, BY_TABLE);
        add_row(OP_BRD, 'h2001, 0, BY_TABLE);
        add_row(OP_BRD, 'h2009, 0, BY_MODEL);
    endtask

    task automatic apply_row(input row_t r);
        logic [mmap_pkg::DATA_W-1:0] exp_v;
        logic                        is_vid;
        int                          g;
        exp_v  = r.by_model ? model_read(r.addr) : r.exp;
        is_vid = r.addr[mmap_pkg::VID_MSB];
        g      = int'(r.addr);
        case (r.op)
            OP_AWR: begin
                a_wr   = 1'b1;
                a_addr = r.addr[mmap_pkg::RAM_ADDR_W-1:0];
                a_din  = r.data;
                ram_m[a_addr] = r.data;
                @(negedge a_clk);
                a_wr = 1'b0;
            end
            OP_ARD: begin
                a_addr = r.addr[mmap_pkg::RAM_ADDR_W-1:0];
                @(negedge a_clk);
                check_eq("a_dout", a_dout, ram_m[a_addr]);
            end
            OP_BWR: begin
                b_wr   = 1'b1;
                b_addr = r.addr;
                b_din  = r.data;
                update_write_models(r.addr, r.data);
                @(negedge a_clk);
                b_wr = 1'b0;
                check_eq("sound", sound, sound_m);
                check_eq("vid_wr", vid_wr, is_vid);
                if (is_vid) begin
                    check_eq("vid_addr", vid_addr, r.addr);
                    check_eq("vid_din", vid_din, r.data);
                end
                @(negedge a_clk);
                check_eq("vid_wr", vid_wr, 1'b0);
            end
            OP_BRD: begin
                b_rd   = 1'b1;
                b_addr = r.addr;
                @(negedge a_clk);
                b_rd = 1'b0;
                check_eq("b_dout", b_dout, exp_v);
                // read data holds until the next read
                @(negedge a_clk);
                check_eq("b_dout", b_dout, exp_v);
            end
            OP_TRIG, OP_SENS: begin
                if (r.op == OP_TRIG) p_trigger[g] = 1'b1;
                else p_sens[g] = 1'b1;
                @(negedge a_clk);
                p_trigger = '0;
                p_sens    = '0;
                if (r.exp[0]) begin
                    wait_flag_set(r.op == OP_SENS, g);
                end else begin
                    // sync stages plus flag register, with margin
                    repeat (5) @(negedge a_clk);
                    check_eq(r.op == OP_SENS ? "hit" : "shot",
                             r.op == OP_SENS ? hit[g] : shot[g], 1'b0);
                end
            end
            OP_IDLE: repeat (r.addr) @(negedge a_clk);
        endcase
    endtask

    initial begin
        int unsigned seed;
        logic [31:0] unused_rnd;
        a_wr        = 1'b0;
        a_addr      = '0;
        a_din       = '0;
        b_rd        = 1'b0;
        b_wr        = 1'b0;
        b_addr      = '0;
        b_din       = '0;
        p_trigger   = '0;
        p_sens      = '0;
        sound_m     = '0;
        lfsr_chk_on = 1'b0;
        seed        = 32'h9996a701;
        unused_rnd  = $urandom(seed);
        build_table();

        // reset values, sampled while reset is held
        @(posedge a_clk);
        @(negedge a_clk);
        check_eq("sound", sound, '0);
        check_eq("shot", shot, '0);
        check_eq("hit", hit, '0);
        check_eq("vid_wr", vid_wr, 1'b0);
        check_eq("b_dout", b_dout, '0);
        check_eq("rand_out", rand_out, mmap_pkg::LFSR_SEED);

        wait_reset_release();
        @(negedge a_clk);
        lfsr_chk_on = 1'b1;
        foreach (rows_q[i]) begin
            apply_row(rows_q[i]);
        end
        repeat (4) @(negedge a_clk);
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: list.f
hdl/mmap_pkg.sv
hdl/dp_ram.sv
hdl/lfsr_rand.sv
hdl/gun_channel.sv
hdl/io_decode.sv
hdl/io_readback.sv
hdl/memory_map_top.sv
dv/tb_clk_gen.sv
dv/memory_map_tb.sv

// File: Bender.yml
package:
  name: memory_map

sources:
  - files:
      - hdl/mmap_pkg.sv
      - hdl/dp_ram.sv
      - hdl/lfsr_rand.sv
      - hdl/gun_channel.sv
      - hdl/io_decode.sv
      - hdl/io_readback.sv
      - hdl/memory_map_top.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/memory_map_tb.sv
